// File: rtl/hex_dump_pkg.sv
package hex_dump_pkg;

  // Character width on the output stream
  // Set for 16-bit characters with the zero byte sent first
  localparam bit UTF16_CHARS = 1'b1;

  // Output buffer size and the width of its fill level
  localparam int FIFO_DEPTH = 2048;
  localparam int LEVEL_BITS = 12;

  // ASCII codes emitted by the formatter
  localparam logic [7:0] CHAR_DASH    = 8'h2d;
  localparam logic [7:0] CHAR_SPACE   = 8'h20;
  localparam logic [7:0] CHAR_NEWLINE = 8'h0a;
  localparam logic [7:0] CHAR_MISSING = 8'h78;
  localparam logic [7:0] CHAR_DIGIT   = 8'h30;
  localparam logic [7:0] CHAR_LETTER  = 8'h37;

  // Byte slots of one word as sent
  // Even slots carry the zero byte of a 16-bit character, odd slots the ASCII byte
  localparam logic [3:0] CHAR_SLOT_FIRST = UTF16_CHARS ? 4'd0 : 4'd1;
  localparam logic [3:0] CHAR_SLOT_STEP  = UTF16_CHARS ? 4'd1 : 4'd2;
  localparam logic [3:0] CHAR_SLOT_LAST  = 4'd9;

  // Number of text characters per word: four hex digits plus separator
  localparam int WORD_CHARS = 5;

  // Payload carried through the output FIFO
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } out_char_t;

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
  import hex_dump_pkg::*;
#(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  valid_i,
  output logic                  ready_o,
  input  payload_t              data_i,

  output logic                  valid_o,
  input  logic                  ready_i,
  output payload_t              data_o,

  output logic [LEVEL_BITS-1:0] level_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];

  logic [AW-1:0]         wr_ptr_q;
  logic [AW-1:0]         rd_ptr_q;
  logic [LEVEL_BITS-1:0] level_q;
  logic                  valid_q;
  payload_t              data_q;

  logic push;
  logic pop;
  logic load;
  logic mem_empty;

  // Entries between read and write pointer, modulo the depth
  logic [AW-1:0] ptr_gap;

  // Level counts the memory entries plus the output register
  assign ready_o   = level_q < LEVEL_BITS'(DEPTH);
  assign mem_empty = level_q == LEVEL_BITS'(valid_q);

  assign push = valid_i && ready_o;
  assign pop  = valid_q && ready_i;

  // Refill the output stage when it is empty or being taken this cycle
  assign load = !mem_empty && (!valid_q || ready_i);

  assign valid_o = valid_q;
  assign data_o  = data_q;
  assign level_o = level_q;

  assign ptr_gap = (wr_ptr_q >= rd_ptr_q) ? wr_ptr_q - rd_ptr_q
                                          : AW'(DEPTH) - rd_ptr_q + wr_ptr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      valid_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end

      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end

      if (load) begin
        valid_q <= 1'b1;
      end else if (pop) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Storage and output stage
  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
    if (load) begin
      data_q <= mem[rd_ptr_q];
    end
  end

  // The pointers and the output flag must agree with the stored count
  a_level_bound: assert property (
    @(posedge clock) disable iff (reset)
    level_q <= LEVEL_BITS'(DEPTH) &&
    LEVEL_BITS'(ptr_gap) ==
      ((level_q - LEVEL_BITS'(valid_q)) % LEVEL_BITS'(DEPTH))
  ) else $error("sync_fifo level above depth or out of step with pointers");

  // A stalled output holds its entry until it is taken
  a_out_stable: assert property (
    @(posedge clock) disable iff (reset)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("sync_fifo output changed while stalled");

endmodule

// File: rtl/hex_word_formatter.sv
`timescale 1ns/1ps

module hex_word_formatter
  import hex_dump_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  logic       start_dump_i,
  output logic       is_dumping_o,

  input  logic       s_valid_i,
  output logic       s_ready_o,
  input  logic       s_last_i,
  input  logic       s_keep_i,
  input  logic [7:0] s_data_i,

  output logic       char_valid_o,
  input  logic       char_ready_i,
  output out_char_t  char_o,

  input  logic       fifo_empty_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOW,
    ST_HIGH,
    ST_SERIAL,
    ST_DRAIN
  } state_t;

  state_t     state_q;
  logic       s_ready_q;
  logic       dumping_q;
  logic       char_valid_q;
  logic       last_q;
  logic       dash_q;
  logic [3:0] slot_q;

  // Text of the current word in send order, separator at the end
  logic [7:0] chars_q [WORD_CHARS];

  logic byte_fire;
  logic char_fire;
  logic slot_done;

  function automatic logic [7:0] hex_char(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      return CHAR_DIGIT + 8'(nibble);
    end
    return CHAR_LETTER + 8'(nibble);
  endfunction

  assign byte_fire = s_valid_i && s_ready_q;
  assign char_fire = char_valid_q && char_ready_i;
  assign slot_done = slot_q == CHAR_SLOT_LAST;

  assign s_ready_o    = s_ready_q;
  assign is_dumping_o = dumping_q;
  assign char_valid_o = char_valid_q;

  // Slot index selects a zero byte or one of the word characters
  always_comb begin
    char_o.last = last_q && slot_done;
    char_o.data = slot_q[0] ? chars_q[slot_q[3:1]] : 8'h00;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= ST_IDLE;
      s_ready_q    <= 1'b0;
      dumping_q    <= 1'b0;
      char_valid_q <= 1'b0;
      last_q       <= 1'b0;
      dash_q       <= 1'b1;
      slot_q       <= CHAR_SLOT_FIRST;
    end else begin
      case (state_q)
        ST_IDLE: begin
          last_q <= 1'b0;
          dash_q <= 1'b1;
          if (start_dump_i && s_valid_i) begin
            s_ready_q <= 1'b1;
            dumping_q <= 1'b1;
            state_q   <= ST_LOW;
          end
        end

        ST_LOW: begin
          // Low byte arrives first but prints second
          if (byte_fire) begin
            if (s_last_i) begin
              s_ready_q    <= 1'b0;
              last_q       <= 1'b1;
              char_valid_q <= 1'b1;
              slot_q       <= CHAR_SLOT_FIRST;
              state_q      <= ST_SERIAL;
            end else begin
              state_q <= ST_HIGH;
            end
          end
        end

        ST_HIGH: begin
          if (byte_fire) begin
            s_ready_q    <= 1'b0;
            last_q       <= s_last_i;
            dash_q       <= ~dash_q;
            char_valid_q <= 1'b1;
            slot_q       <= CHAR_SLOT_FIRST;
            state_q      <= ST_SERIAL;
          end
        end

        ST_SERIAL: begin
          if (char_fire) begin
            if (slot_done) begin
              char_valid_q <= 1'b0;
              if (last_q) begin
                state_q <= ST_DRAIN;
              end else begin
                s_ready_q <= 1'b1;
                state_q   <= ST_LOW;
              end
            end else begin
              slot_q <= slot_q + CHAR_SLOT_STEP;
            end
          end
        end

        ST_DRAIN: begin
          // Hold status until the console has taken every byte
          if (fifo_empty_i) begin
            dumping_q <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Character capture, two hex digits per byte
  always_ff @(posedge clock) begin
    if (byte_fire && state_q == ST_LOW) begin
      chars_q[2] <= hex_char(s_data_i[7:4]);
      chars_q[3] <= hex_char(s_data_i[3:0]);
      if (s_last_i) begin
        // Packet ended before the high byte
        chars_q[0] <= CHAR_MISSING;
        chars_q[1] <= CHAR_MISSING;
        chars_q[4] <= CHAR_NEWLINE;
      end
    end
    if (byte_fire && state_q == ST_HIGH) begin
      if (s_keep_i) begin
        chars_q[0] <= hex_char(s_data_i[7:4]);
        chars_q[1] <= hex_char(s_data_i[3:0]);
      end else begin
        chars_q[0] <= CHAR_MISSING;
        chars_q[1] <= CHAR_MISSING;
      end
      if (s_last_i) begin
        chars_q[4] <= CHAR_NEWLINE;
      end else begin
        chars_q[4] <= dash_q ? CHAR_DASH : CHAR_SPACE;
      end
    end
  end

  // A stalled character is held until the FIFO takes it
  a_char_stable: assert property (
    @(posedge clock) disable iff (reset)
    char_valid_o && !char_ready_i |=> char_valid_o && $stable(char_o)
  ) else $error("formatter character changed while stalled");

endmodule

// File: rtl/hex_dump.sv
`timescale 1ns/1ps

module hex_dump
  import hex_dump_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  start_dump_i,
  output logic                  is_dumping_o,
  output logic [LEVEL_BITS-1:0] fifo_level_o,

  input  logic                  s_valid_i,
  output logic                  s_ready_o,
  input  logic                  s_last_i,
  input  logic                  s_keep_i,
  input  logic [7:0]            s_data_i,

  output logic                  m_valid_o,
  input  logic                  m_ready_i,
  output logic                  m_last_o,
  output logic [7:0]            m_data_o
);

  logic                  char_valid;
  logic                  char_ready;
  out_char_t             char;
  out_char_t             fifo_out;
  logic [LEVEL_BITS-1:0] fifo_level;
  logic                  fifo_empty;

  assign fifo_empty   = fifo_level == '0;
  assign fifo_level_o = fifo_level;
  assign m_last_o     = fifo_out.last;
  assign m_data_o     = fifo_out.data;

  hex_word_formatter formatter_i (
    .clock        (clock),
    .reset        (reset),
    .start_dump_i (start_dump_i),
    .is_dumping_o (is_dumping_o),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .s_last_i     (s_last_i),
    .s_keep_i     (s_keep_i),
    .s_data_i     (s_data_i),
    .char_valid_o (char_valid),
    .char_ready_i (char_ready),
    .char_o       (char),
    .fifo_empty_i (fifo_empty)
  );

  // Output buffer towards the console
  sync_fifo #(
    .payload_t (out_char_t),
    .DEPTH     (FIFO_DEPTH)
  ) fifo_i (
    .clock   (clock),
    .reset   (reset),
    .valid_i (char_valid),
    .ready_o (char_ready),
    .data_i  (char),
    .valid_o (m_valid_o),
    .ready_i (m_ready_i),
    .data_o  (fifo_out),
    .level_o (fifo_level)
  );

endmodule

// File: testbench/hex_dump_model.svh
`ifndef HEX_DUMP_MODEL_SVH
`define HEX_DUMP_MODEL_SVH

// Upper-case hex digit for one nibble
function automatic logic [7:0] nibble_ascii(input logic [3:0] nibble);
  string digits;
  digits = "0123456789ABCDEF";
  return digits.getc(int'(nibble));
endfunction

// Expected console bytes for one packet
// Entries hold the last flag above the data byte
// Bytes pair up little-endian and the high byte prints first
task automatic build_expected(
  input  logic [7:0] data[$],
  input  logic       keep[$],
  output logic [8:0] expected[$]
);
  logic [7:0] text[5];
  logic [7:0] low_byte;
  logic [7:0] high_byte;
  int         words;
  int         lo;
  logic       final_word;
  expected = {};
  words = (data.size() + 1) / 2;
  for (int w = 0; w < words; w++) begin
    lo = 2 * w;
    final_word = (w == words - 1);
    low_byte = data[lo];
    if (lo + 1 < data.size() && keep[lo + 1]) begin
      high_byte = data[lo + 1];
      text[0] = nibble_ascii(high_byte[7:4]);
      text[1] = nibble_ascii(high_byte[3:0]);
    end else begin
      // Missing or unkept high byte
      text[0] = "x";
      text[1] = "x";
    end
    text[2] = nibble_ascii(low_byte[7:4]);
    text[3] = nibble_ascii(low_byte[3:0]);
    if (final_word) begin
      text[4] = 8'h0a;
    end else if (w % 2 == 0) begin
      text[4] = "-";
    end else begin
      text[4] = " ";
    end
    for (int c = 0; c < 5; c++) begin
      if (UTF16_CHARS) begin
        expected.push_back({1'b0, 8'h00});
      end
      expected.push_back({final_word && (c == 4), text[c]});
    end
  end
endtask

`endif

// File: testbench/hex_dump_tb.sv
`timescale 1ns/1ps

module hex_dump_tb
  import hex_dump_pkg::*;
();

  localparam logic [31:0] SEED       = 32'hbf1c_d89f;
  localparam int          WAIT_LIMIT = 100000;

  logic                  clock;
  logic                  reset;
  logic                  start_dump_i;
  logic                  s_valid_i;
  logic                  s_last_i;
  logic                  s_keep_i;
  logic [7:0]            s_data_i;
  logic                  m_ready_i;
  logic                  s_ready_o;
  logic                  is_dumping_o;
  logic [LEVEL_BITS-1:0] fifo_level_o;
  logic                  m_valid_o;
  logic                  m_last_o;
  logic [7:0]            m_data_o;

  int         error_count;
  int         max_level;
  logic [8:0] expected_q[$];

  `include "hex_dump_model.svh"

  hex_dump dut_i (
    .clock        (clock),
    .reset        (reset),
    .start_dump_i (start_dump_i),
    .is_dumping_o (is_dumping_o),
    .fifo_level_o (fifo_level_o),
    .s_valid_i    (s_valid_i),
    .s_ready_o    (s_ready_o),
    .s_last_i     (s_last_i),
    .s_keep_i     (s_keep_i),
    .s_data_i     (s_data_i),
    .m_valid_o    (m_valid_o),
    .m_ready_i    (m_ready_i),
    .m_last_o     (m_last_o),
    .m_data_o     (m_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s expected %0h actual %0h", test, expected, actual);
      abort_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic drive_byte(input logic [7:0] value, input logic keep, input logic last);
    s_valid_i <= 1'b1;
    s_data_i  <= value;
    s_keep_i  <= keep;
    s_last_i  <= last;
  endtask

  // Feed the packet with random valid gaps and hold each byte until taken
  task automatic send_bytes(input string name, input logic [7:0] data[$],
                            input logic keep[$]);
    int idx;
    int cycles;
    idx = 0;
    cycles = 0;
    while (idx < data.size()) begin
      @(posedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timeout_fail({name, " input bytes"});
      end
      check_value({name, " dumping while sending"}, 1, 32'(is_dumping_o));
      if (s_valid_i && s_ready_o) begin
        idx++;
        if (idx < data.size() && ($urandom % 4) != 0) begin
          drive_byte(data[idx], keep[idx], idx == data.size() - 1);
        end else begin
          s_valid_i <= 1'b0;
          s_last_i  <= 1'b0;
        end
      end else if (!s_valid_i) begin
        drive_byte(data[idx], keep[idx], idx == data.size() - 1);
      end
    end
  endtask

  // Compare console bytes with the model while steering back-pressure
  task automatic collect_output(input string name, input int mode);
    int         cycles;
    int         stall;
    logic [8:0] want;
    cycles = 0;
    stall = 0;
    while (expected_q.size() > 0) begin
      @(posedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timeout_fail({name, " console output"});
      end
      check_value({name, " dumping until drained"}, 1, 32'(is_dumping_o));
      check_value({name, " level within depth"}, 1, 32'(int'(fifo_level_o) <= FIFO_DEPTH));
      if (int'(fifo_level_o) > max_level) begin
        max_level = int'(fifo_level_o);
      end
      if (m_valid_o && m_ready_i) begin
        want = expected_q.pop_front();
        check_value({name, " output byte"}, 32'(want), 32'({m_last_o, m_data_o}));
      end
      if (mode == 0) begin
        m_ready_i <= 1'b1;
      end else if (mode == 2) begin
        if (stall > 0) begin
          stall--;
          m_ready_i <= 1'b0;
        end else if (($urandom % 16) == 0) begin
          stall = 20 + int'($urandom % 200);
          m_ready_i <= 1'b0;
        end else begin
          m_ready_i <= 1'b1;
        end
      end else if (mode == 3 && max_level < FIFO_DEPTH) begin
        // Hold off the console until the buffer is full
        m_ready_i <= 1'b0;
      end else begin
        m_ready_i <= ($urandom % 2) == 0;
      end
    end
  endtask

  task automatic run_packet(input string name, input int length, input int keep_drop,
                            input int mode);
    logic [7:0] data[$];
    logic       keep[$];
    int         gap;
    int         cycles;
    for (int i = 0; i < length; i++) begin
      data.push_back(8'($urandom));
      keep.push_back(keep_drop == 0 || ($urandom % 32'(keep_drop)) != 0);
    end
    build_expected(data, keep, expected_q);
    max_level = 0;
    m_ready_i <= (mode != 3);

    // First byte waits on the bus while no start is requested
    drive_byte(data[0], keep[0], length == 1);
    gap = 2 + int'($urandom % 20);
    for (int i = 0; i < gap; i++) begin
      @(posedge clock);
      check_value({name, " ready without start"}, 0, 32'(s_ready_o));
      check_value({name, " output without start"}, 0, 32'(m_valid_o));
      check_value({name, " dumping without start"}, 0, 32'(is_dumping_o));
    end
    start_dump_i <= 1'b1;
    @(posedge clock);
    // Start edge itself accepts no byte
    check_value({name, " ready on start cycle"}, 0, 32'(s_ready_o));
    start_dump_i <= 1'b0;

    fork
      send_bytes(name, data, keep);
      collect_output(name, mode);
    join

    m_ready_i <= 1'b1;
    cycles = 0;
    while (is_dumping_o) begin
      @(posedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        timeout_fail({name, " end of dump"});
      end
      check_value({name, " extra output"}, 0, 32'(m_valid_o));
    end
    check_value({name, " level after dump"}, 0, 32'(fifo_level_o));
    if (mode == 3) begin
      check_value({name, " buffer filled"}, FIFO_DEPTH, max_level);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    error_count  = 0;
    max_level    = 0;
    reset        = 1'b1;
    start_dump_i = 1'b0;
    s_valid_i    = 1'b0;
    s_last_i     = 1'b0;
    s_keep_i     = 1'b0;
    s_data_i     = 8'h00;
    m_ready_i    = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    check_value("reset s_ready", 0, 32'(s_ready_o));
    check_value("reset m_valid", 0, 32'(m_valid_o));
    check_value("reset dumping", 0, 32'(is_dumping_o));
    check_value("reset level", 0, 32'(fifo_level_o));

    for (int k = 0; k < 12; k++) begin
      run_packet($sformatf("even packet %0d", k), 2 * (1 + int'($urandom % 16)), 0, k % 2);
    end
    run_packet("single byte", 1, 0, 0);
    for (int k = 0; k < 10; k++) begin
      run_packet($sformatf("odd packet %0d", k), 1 + 2 * int'($urandom % 16), 3, 1);
    end
    for (int k = 0; k < 8; k++) begin
      run_packet($sformatf("stall packet %0d", k), 1 + int'($urandom % 32), 4, 2);
    end
    run_packet("full buffer", UTF16_CHARS ? 480 : 960, 5, 3);

    if (error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: hex_dump.f
+incdir+testbench
rtl/hex_dump_pkg.sv
rtl/sync_fifo.sv
rtl/hex_word_formatter.sv
rtl/hex_dump.sv
testbench/hex_dump_tb.sv

// File: Makefile
# Verilator build and run for the hex dump subsystem

VERILATOR  ?= verilator
FILELIST   := hex_dump.f
TB_TOP     := hex_dump_tb
RTL_TOP    := hex_dump
BUILD_DIR  := obj_dir

LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# Lint the design on its own top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build and run the testbench; a $fatal gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
